/* dv/tb_infra_ctrl.sv */
`timescale 1ns/1ps

module tb_infra_ctrl import infra_pkg::*, ps_pkg::*; ();

  localparam logic [31:0] SEED = 32'h6daa;
  localparam int RAND_CMDS = 16;
  localparam int BP_CMDS   = 5;
  // random steps are 0..15, the range walk needs at most 9 commands of 63
  localparam int STEP_BUDGET = RAND_CMDS * 15 + 9 * 63 + BP_CMDS * 15 + 10;
  // a step costs at most 9 cycles, plus reset, lock phases and one psdone timeout
  localparam int MAX_CYCLES = STEP_BUDGET * 9 + 1500;
  // more answers than any command has steps
  localparam int ALL_ANSWERED = 64;

  logic       clk_bufg;
  logic       rst_tmp;
  logic       pll_lock;
  logic       iodelay_ctrl_rdy;
  logic       cmd_valid;
  ps_cmd_t    cmd;
  logic       cmd_ready;
  logic       resp_valid;
  ps_resp_t   resp;
  logic       resp_ready;
  logic       psen;
  logic       psincdec;
  logic       psdone;
  logic       rstdiv0;
  lock_stat_t lock_stat;

  // random state, one stream for commands and one for psdone delays
  logic [31:0] stim_rng = SEED;
  logic [31:0] dly_rng = SEED;

  // MMCM model controls, mute_after below zero answers every pulse
  bit  hold_resp = 1'b0;
  bit  mute = 1'b0;
  int  mute_after = -1;
  int  pulse_cnt = 0;
  int  inc_cnt = 0;

  // model tap and expectations in command order
  int       model_tap = 0;
  ps_resp_t exp_q[$];
  int       pulses_q[$];
  int       incs_q[$];

  int value_errs = 0;
  int other_errs = 0;
  int cycle_cnt = 0;

  infra_ctrl_top u_dut (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rst_tmp),
    .pll_lock         (pll_lock),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .cmd_valid        (cmd_valid),
    .cmd              (cmd),
    .cmd_ready        (cmd_ready),
    .resp_valid       (resp_valid),
    .resp             (resp),
    .resp_ready       (resp_ready),
    .psen             (psen),
    .psincdec         (psincdec),
    .psdone           (psdone),
    .rstdiv0          (rstdiv0),
    .lock_stat        (lock_stat)
  );

  initial begin : clock_gen
    clk_bufg = 1'b0;
    forever #10 clk_bufg = ~clk_bufg;
  end

  // ****************************************
  // reference model and helpers
  // ****************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // answered is how many psdone the MMCM gives before going quiet
  function automatic ps_resp_t ref_resp(input int tap_now, input ps_cmd_t c,
                                        input int answered);
    ps_resp_t r;
    int       sgn;
    int       steps;
    int       n;
    sgn   = (c.dir == PS_INC) ? 1 : -1;
    steps = int'(c.steps);
    r.status     = PS_OK;
    r.tap        = PS_TAP_W'(tap_now);
    r.done_steps = '0;
    if ((tap_now + sgn * steps > 448) || (tap_now + sgn * steps < -448)) begin
      // rejected before any pulse
      r.status = PS_RANGE;
    end else begin
      n = (answered < steps) ? answered : steps;
      if (n < steps) begin
        r.status = PS_TIMEOUT;
      end
      r.tap        = PS_TAP_W'(tap_now + sgn * n);
      r.done_steps = PS_STEP_W'(n);
    end
    return r;
  endfunction

  task automatic check_resp(input string name, input ps_resp_t exp, input ps_resp_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected status %0d tap %0d done %0d actual status %0d tap %0d done %0d",
               $time, name, exp.status, exp.tap, exp.done_steps,
               act.status, act.tap, act.done_steps);
      value_errs++;
    end
  endtask

  task automatic check_stat(input string name, input lock_stat_t exp, input lock_stat_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected ready %b losses %0d actual ready %b losses %0d",
               $time, name, exp.infra_ready, exp.loss_cnt, act.infra_ready, act.loss_cnt);
      value_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic rand_cmd(output ps_cmd_t c);
    stim_rng = xorshift32(stim_rng);
    c.dir   = stim_rng[16] ? PS_INC : PS_DEC;
    c.steps = PS_STEP_W'(stim_rng[3:0]);
  endtask

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic push_cmd(input ps_cmd_t c);
    cmd_valid = 1'b1;
    cmd       = c;
    while (!cmd_ready) @(negedge clk_bufg);
    @(negedge clk_bufg);
    cmd_valid = 1'b0;
  endtask

  task automatic expect_and_push(input ps_cmd_t c, input int answered,
                                 output ps_status_e st);
    ps_resp_t exp;
    int       pulses;
    exp = ref_resp(model_tap, c, answered);
    model_tap = int'(exp.tap);
    // the unanswered pulse of a timeout still goes out
    if (exp.status == PS_RANGE) begin
      pulses = 0;
    end else begin
      pulses = int'(exp.done_steps) + ((exp.status == PS_TIMEOUT) ? 1 : 0);
    end
    exp_q.push_back(exp);
    pulses_q.push_back(pulses);
    incs_q.push_back((c.dir == PS_INC) ? pulses : 0);
    st = exp.status;
    push_cmd(c);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_bufg);
  endtask

  task automatic wait_ready(input int lo, input int hi);
    int n;
    n = 0;
    while (!lock_stat.infra_ready && (n <= hi)) begin
      @(negedge clk_bufg);
      n++;
    end
    if ((n < lo) || (n > hi)) begin
      $display("infra_ready took %0d cycles instead of %0d to %0d at %0t", n, lo, hi, $time);
      other_errs++;
    end
  endtask

  // drop one lock input, ready must clear within 3 cycles
  task automatic drop_lock(input bit use_pll, input int losses);
    lock_stat_t exp_stat;
    int         n;
    if (use_pll) begin
      pll_lock = 1'b0;
    end else begin
      iodelay_ctrl_rdy = 1'b0;
    end
    n = 0;
    while (lock_stat.infra_ready && (n < 3)) begin
      @(negedge clk_bufg);
      n++;
    end
    exp_stat.infra_ready = 1'b0;
    exp_stat.loss_cnt    = LOSS_CNT_W'(losses);
    check_stat("lock_stat", exp_stat, lock_stat);
  endtask

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // ****************************************
  // MMCM psdone responder
  // ****************************************

  initial begin : mmcm_model
    int dly;
    dly    = 0;
    psdone = 1'b0;
    forever begin
      @(negedge clk_bufg);
      psdone = 1'b0;
      if (dly > 0) begin
        dly--;
        if (dly == 0) begin
          psdone = 1'b1;
        end
      end
      if (psen) begin
        pulse_cnt++;
        if (psincdec) begin
          inc_cnt++;
        end
        // go quiet once the answer budget is used up
        if (mute_after == 0) begin
          mute = 1'b1;
        end else if (mute_after > 0) begin
          mute_after--;
        end
        if (!mute) begin
          dly_rng = xorshift32(dly_rng);
          dly     = int'(dly_rng[2:0]) + 1;
        end
      end
    end
  end

  // response side, the handshake is decided here on the falling edge
  initial begin : resp_monitor
    ps_resp_t exp;
    int       exp_pulses;
    int       exp_incs;
    resp_ready = 1'b0;
    forever begin
      @(negedge clk_bufg);
      resp_ready = !hold_resp;
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("response at %0t with no command outstanding", $time);
          other_errs++;
        end else begin
          exp        = exp_q.pop_front();
          exp_pulses = pulses_q.pop_front();
          exp_incs   = incs_q.pop_front();
          check_resp("resp", exp, resp);
          check_count("psen pulses", exp_pulses, pulse_cnt);
          check_count("psincdec high pulses", exp_incs, inc_cnt);
        end
        pulse_cnt = 0;
        inc_cnt   = 0;
      end
    end
  end

  initial begin : cycle_limit
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_bufg);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles with tests still running", MAX_CYCLES);
    other_errs++;
    finish_run();
  end

  // ****************************************
  // stimulus
  // ****************************************

  initial begin : stimulus
    ps_cmd_t    c;
    lock_stat_t exp_stat;
    ps_status_e st;
    int         i;
    rst_tmp          = 1'b1;
    pll_lock         = 1'b0;
    iodelay_ctrl_rdy = 1'b0;
    cmd_valid        = 1'b0;
    cmd              = '0;

    // reset release, 8 edges after rst_tmp falls
    repeat (3) begin
      @(negedge clk_bufg);
      check_bit("rstdiv0", 1'b1, rstdiv0);
    end
    check_bit("psen", 1'b0, psen);
    check_bit("resp_valid", 1'b0, resp_valid);
    exp_stat = '0;
    check_stat("lock_stat", exp_stat, lock_stat);
    rst_tmp = 1'b0;
    for (i = 1; i <= RST_DIV_SYNC_NUM; i++) begin
      @(negedge clk_bufg);
      check_bit("rstdiv0", (i < RST_DIV_SYNC_NUM), rstdiv0);
    end

    // lock qualification and two losses
    pll_lock         = 1'b1;
    iodelay_ctrl_rdy = 1'b1;
    wait_ready(18, 19);
    drop_lock(1'b1, 1);
    pll_lock = 1'b1;
    wait_ready(18, 19);
    drop_lock(1'b0, 2);
    iodelay_ctrl_rdy = 1'b1;
    wait_ready(18, 19);

    // random stepping
    for (i = 0; i < RAND_CMDS; i++) begin
      rand_cmd(c);
      expect_and_push(c, ALL_ANSWERED, st);
    end
    wait_drain();

    // walk to the nearer limit until a command gets rejected
    c.dir   = (model_tap >= 0) ? PS_INC : PS_DEC;
    c.steps = PS_STEP_W'(63);
    st      = PS_OK;
    i       = 0;
    while ((st != PS_RANGE) && (i < 10)) begin
      expect_and_push(c, ALL_ANSWERED, st);
      i++;
    end
    wait_drain();

    // MMCM stops answering after 3 pulses
    mute_after = 3;
    c.dir      = (model_tap >= 0) ? PS_DEC : PS_INC;
    c.steps    = PS_STEP_W'(10);
    expect_and_push(c, 3, st);
    wait_drain();
    mute       = 1'b0;
    mute_after = -1;

    // back-pressure, one command held in the controller and four queued
    @(posedge clk_bufg);
    hold_resp = 1'b1;
    @(negedge clk_bufg);
    for (i = 0; i < BP_CMDS; i++) begin
      rand_cmd(c);
      expect_and_push(c, ALL_ANSWERED, st);
    end
    repeat (10) @(negedge clk_bufg);
    check_bit("cmd_ready", 1'b0, cmd_ready);
    @(posedge clk_bufg);
    hold_resp = 1'b0;
    @(negedge clk_bufg);
    wait_drain();
    repeat (4) @(negedge clk_bufg);
    finish_run();
  end

endmodule

/* hw/infra_ctrl_top.sv */
`timescale 1ns/1ps

module infra_ctrl_top import infra_pkg::*, ps_pkg::*; (
  input  logic       clk_bufg,
  input  logic       rst_tmp,
  input  logic       pll_lock,
  input  logic       iodelay_ctrl_rdy,
  // client command side
  input  logic       cmd_valid,
  input  ps_cmd_t    cmd,
  output logic       cmd_ready,
  // client response side
  output logic       resp_valid,
  output ps_resp_t   resp,
  input  logic       resp_ready,
  // MMCM fine phase shift port
  output logic       psen,
  output logic       psincdec,
  input  logic       psdone,
  // status
  output logic       rstdiv0,
  output lock_stat_t lock_stat
);

  // queue head toward the controller
  logic    q_valid;
  ps_cmd_t q_cmd;
  logic    q_ready;

  // ****************************************
  // reset and lock status
  // ****************************************

  rst_div_sync u_rst_div_sync (
    .clk_bufg (clk_bufg),
    .rst_tmp  (rst_tmp),
    .rstdiv0  (rstdiv0)
  );

  lock_monitor u_lock_monitor (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rst_tmp),
    .rstdiv0          (rstdiv0),
    .pll_lock         (pll_lock),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .lock_stat        (lock_stat)
  );

  // ****************************************
  // phase-shift path
  // ****************************************

  ps_cmd_fifo u_ps_cmd_fifo (
    .clk_bufg  (clk_bufg),
    .rst_tmp   (rst_tmp),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .q_valid   (q_valid),
    .q_cmd     (q_cmd),
    .q_ready   (q_ready)
  );

  ps_ctrl u_ps_ctrl (
    .clk_bufg   (clk_bufg),
    .rst_tmp    (rst_tmp),
    .lock_stat  (lock_stat),
    .q_valid    (q_valid),
    .q_cmd      (q_cmd),
    .q_ready    (q_ready),
    .psen       (psen),
    .psincdec   (psincdec),
    .psdone     (psdone),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready)
  );

endmodule

/* hw/infra_pkg.sv */
package infra_pkg;

  // ****************************************
  // reset release
  // ****************************************

  // stages in the rstdiv0 release shift register
  localparam int RST_DIV_SYNC_NUM = 8;

  // ****************************************
  // lock qualification
  // ****************************************

  // depth of the double-flop synchronizer on the lock inputs
  localparam int LOCK_SYNC_STAGES = 2;

  // consecutive good cycles before the infrastructure is declared ready
  localparam int LOCK_STABLE_CYCLES = 16;

  // width of the stable-cycle counter, must reach LOCK_STABLE_CYCLES
  localparam int LOCK_CNT_W = $clog2(LOCK_STABLE_CYCLES + 1);

  // lock-loss counter width, saturates at all ones
  localparam int LOSS_CNT_W = 8;

  // status seen by the phase-shift controller and the outside world
  typedef struct packed {
    logic                  infra_ready;
    logic [LOSS_CNT_W-1:0] loss_cnt;
  } lock_stat_t;

endpackage

/* hw/lock_monitor.sv */
`timescale 1ns/1ps

module lock_monitor import infra_pkg::*; (
  input  logic       clk_bufg,
  input  logic       rst_tmp,
  input  logic       rstdiv0,
  input  logic       pll_lock,
  input  logic       iodelay_ctrl_rdy,
  output lock_stat_t lock_stat
);

  // ****************************************
  // input synchronizer
  // ****************************************

  // bit 1 is pll_lock, bit 0 is iodelay_ctrl_rdy
  // element 0 is the first flop of the chain
  logic [LOCK_SYNC_STAGES-1:0][1:0] sync_r;
  logic                             lock_sync;

  // stable-cycle counter for qualification
  logic [LOCK_CNT_W-1:0]            stable_cnt;

  // both inputs good after the last stage
  assign lock_sync = &sync_r[LOCK_SYNC_STAGES-1];

  // ****************************************
  // qualification and loss counting
  // ****************************************

  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      sync_r               <= '0;
      stable_cnt           <= '0;
      lock_stat.infra_ready <= 1'b0;
      lock_stat.loss_cnt   <= '0;
    end else begin
      sync_r <= {sync_r[LOCK_SYNC_STAGES-2:0], {pll_lock, iodelay_ctrl_rdy}};

      // lock dropped while ready, count it once
      // ready clears on this same edge, so no double count
      if (lock_stat.infra_ready && !lock_sync && (lock_stat.loss_cnt != '1)) begin
        lock_stat.loss_cnt <= lock_stat.loss_cnt + LOSS_CNT_W'(1);
      end

      // any bad cycle or fabric reset restarts qualification
      if (rstdiv0 || !lock_sync) begin
        stable_cnt            <= '0;
        lock_stat.infra_ready <= 1'b0;
      end else if (stable_cnt != LOCK_CNT_W'(LOCK_STABLE_CYCLES)) begin
        stable_cnt <= stable_cnt + LOCK_CNT_W'(1);
        // last qualifying cycle
        if (stable_cnt == LOCK_CNT_W'(LOCK_STABLE_CYCLES - 1)) begin
          lock_stat.infra_ready <= 1'b1;
        end
      end
    end
  end

  // ****************************************
  // checks
  // ****************************************

  // loss count only ever grows until the next rst_tmp
  a_loss_monotonic : assert property (
    @(posedge clk_bufg) disable iff (rst_tmp)
      lock_stat.loss_cnt >= $past(lock_stat.loss_cnt)
  ) else $error("loss_cnt decreased outside reset");

endmodule

/* hw/ps_cmd_fifo.sv */
`timescale 1ns/1ps

module ps_cmd_fifo import ps_pkg::*; (
  input  logic    clk_bufg,
  input  logic    rst_tmp,
  input  logic    cmd_valid,
  input  ps_cmd_t cmd,
  output logic    cmd_ready,
  output logic    q_valid,
  output ps_cmd_t q_cmd,
  input  logic    q_ready
);

  // command storage, written at wr_ptr on each push
  ps_cmd_t             mem [PS_FIFO_DEPTH];

  // pointers wrap naturally, depth is a power of two
  logic [PS_PTR_W-1:0] wr_ptr;
  logic [PS_PTR_W-1:0] rd_ptr;
  logic [PS_PTR_W:0]   count;

  logic                push;
  logic                pop;

  assign cmd_ready = (count != (PS_PTR_W + 1)'(PS_FIFO_DEPTH));
  assign q_valid   = (count != '0);
  assign push      = cmd_valid && cmd_ready;
  assign pop       = q_ready && q_valid;

  // first-word fall-through, head is always on the output
  assign q_cmd = mem[rd_ptr];

  always_ff @(posedge clk_bufg) begin
    if (push) begin
      mem[wr_ptr] <= cmd;
    end
  end

  // ****************************************
  // pointers and occupancy
  // ****************************************

  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + PS_PTR_W'(1);
      if (pop)  rd_ptr <= rd_ptr + PS_PTR_W'(1);
      // simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + (PS_PTR_W + 1)'(1);
        2'b01:   count <= count - (PS_PTR_W + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  // controller must only take an entry that exists
  a_no_pop_empty : assert property (
    @(posedge clk_bufg) disable iff (rst_tmp) q_ready |-> q_valid
  ) else $error("q_ready high with empty command queue");

endmodule

/* hw/ps_ctrl.sv */
`timescale 1ns/1ps

module ps_ctrl import infra_pkg::*, ps_pkg::*; (
  input  logic       clk_bufg,
  input  logic       rst_tmp,
  input  lock_stat_t lock_stat,
  input  logic       q_valid,
  input  ps_cmd_t    q_cmd,
  output logic       q_ready,
  output logic       psen,
  output logic       psincdec,
  input  logic       psdone,
  output logic       resp_valid,
  output ps_resp_t   resp,
  input  logic       resp_ready
);

  ps_state_e                  state;

  // command under execution
  ps_cmd_t                    cmd_r;
  ps_status_e                 status_r;

  // current MMCM phase position in taps
  logic signed [PS_TAP_W-1:0] tap;
  logic [PS_STEP_W-1:0]       done_cnt;
  logic [PS_WAIT_W-1:0]       wait_cnt;

  // tap the command would end on, one bit wider to catch overflow
  logic signed [PS_TAP_W:0]   tap_final;
  logic                       range_err;
  logic                       last_step;
  logic                       wait_expired;

  // take the head only when idle and the clocks are good
  assign q_ready = (state == PS_IDLE) && q_valid && lock_stat.infra_ready;

  always_comb begin
    if (cmd_r.dir == PS_INC) begin
      tap_final = tap + $signed({1'b0, cmd_r.steps});
    end else begin
      tap_final = tap - $signed({1'b0, cmd_r.steps});
    end
  end

  assign range_err    = (tap_final > PS_MAX_TAP) || (tap_final < -PS_MAX_TAP);
  assign last_step    = ((done_cnt + PS_STEP_W'(1)) == cmd_r.steps);
  assign wait_expired = (wait_cnt == PS_WAIT_W'(PS_DONE_TIMEOUT - 1));

  always_ff @(posedge clk_bufg) begin
    if (q_ready) begin
      cmd_r <= q_cmd;
    end
  end

  // status is settled in PS_CHECK and only overridden by a timeout
  always_ff @(posedge clk_bufg) begin
    if (state == PS_CHECK) begin
      status_r <= range_err ? PS_RANGE : PS_OK;
    end else if ((state == PS_WAIT) && !psdone && wait_expired) begin
      status_r <= PS_TIMEOUT;
    end
  end

  // ****************************************
  // command FSM
  // ****************************************

  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      state      <= PS_IDLE;
      tap        <= '0;
      done_cnt   <= '0;
      wait_cnt   <= '0;
      psen       <= 1'b0;
      psincdec   <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      // psen is high only for the cycle spent in PS_PULSE
      psen <= 1'b0;
      case (state)
        PS_IDLE: begin
          if (q_ready) begin
            done_cnt <= '0;
            state    <= PS_CHECK;
          end
        end
        PS_CHECK: begin
          // out of range or nothing to do, answer without pulsing
          if (range_err || (cmd_r.steps == '0)) begin
            resp_valid <= 1'b1;
            state      <= PS_RESP;
          end else begin
            psen     <= 1'b1;
            psincdec <= (cmd_r.dir == PS_INC);
            state    <= PS_PULSE;
          end
        end
        PS_PULSE: begin
          wait_cnt <= '0;
          state    <= PS_WAIT;
        end
        PS_WAIT: begin
          if (psdone) begin
            tap      <= (cmd_r.dir == PS_INC) ? tap + PS_TAP_W'(1) : tap - PS_TAP_W'(1);
            done_cnt <= done_cnt + PS_STEP_W'(1);
            if (last_step) begin
              resp_valid <= 1'b1;
              state      <= PS_RESP;
            end else begin
              psen  <= 1'b1;
              state <= PS_PULSE;
            end
          end else if (wait_expired) begin
            // MMCM went quiet, report what got done
            resp_valid <= 1'b1;
            state      <= PS_RESP;
          end else begin
            wait_cnt <= wait_cnt + PS_WAIT_W'(1);
          end
        end
        PS_RESP: begin
          if (resp_ready) begin
            resp_valid <= 1'b0;
            state      <= PS_IDLE;
          end
        end
        default: state <= PS_IDLE;
      endcase
    end
  end

  assign resp = '{status: status_r, tap: tap, done_steps: done_cnt};

  // ****************************************
  // checks
  // ****************************************

  a_psen_single : assert property (
    @(posedge clk_bufg) disable iff (rst_tmp) psen |=> !psen
  ) else $error("psen held longer than one cycle");

  // one pulse outstanding, no new pulse while waiting for psdone
  a_psen_not_in_wait : assert property (
    @(posedge clk_bufg) disable iff (rst_tmp) (state == PS_WAIT) |-> !$rose(psen)
  ) else $error("psen rose while waiting for psdone");

  a_resp_hold : assert property (
    @(posedge clk_bufg) disable iff (rst_tmp)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  ) else $error("response dropped or changed before acceptance");

endmodule

/* hw/ps_pkg.sv */
package ps_pkg;

  // ****************************************
  // phase-shift constants
  // ****************************************

  // signed tap position width
  localparam int PS_TAP_W = 10;

  // largest allowed tap magnitude in either direction
  localparam int PS_MAX_TAP = 448;

  // step count carried by one command
  localparam int PS_STEP_W = 6;

  // cycles to wait for psdone after each psen pulse
  localparam int PS_DONE_TIMEOUT = 64;
  localparam int PS_WAIT_W = $clog2(PS_DONE_TIMEOUT);

  // command queue
  localparam int PS_FIFO_DEPTH = 4;
  localparam int PS_PTR_W = $clog2(PS_FIFO_DEPTH);

  // ****************************************
  // enums and structs
  // ****************************************

  // psincdec encoding on the MMCM port
  typedef enum logic {
    PS_DEC = 1'b0,
    PS_INC = 1'b1
  } ps_dir_e;

  typedef enum logic [1:0] {
    PS_OK      = 2'd0,
    PS_RANGE   = 2'd1,
    PS_TIMEOUT = 2'd2
  } ps_status_e;

  typedef enum logic [2:0] {
    PS_IDLE  = 3'd0,
    PS_CHECK = 3'd1,
    PS_PULSE = 3'd2,
    PS_WAIT  = 3'd3,
    PS_RESP  = 3'd4
  } ps_state_e;

  typedef struct packed {
    ps_dir_e                dir;
    logic [PS_STEP_W-1:0]   steps;
  } ps_cmd_t;

  typedef struct packed {
    ps_status_e                  status;
    logic signed [PS_TAP_W-1:0]  tap;
    logic [PS_STEP_W-1:0]        done_steps;
  } ps_resp_t;

endpackage

/* hw/rst_div_sync.sv */
`timescale 1ns/1ps

module rst_div_sync import infra_pkg::*; (
  input  logic clk_bufg,
  input  logic rst_tmp,
  output logic rstdiv0
);

  // ****************************************
  // reset stretcher
  // ****************************************

  // all ones while rst_tmp is high
  // a zero walks in from the bottom after release
  logic [RST_DIV_SYNC_NUM-1:0] rstdiv0_sync_r;

  // assert asynchronously, release on the clock
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      rstdiv0_sync_r <= '1;
    end else begin
      rstdiv0_sync_r <= {rstdiv0_sync_r[RST_DIV_SYNC_NUM-2:0], 1'b0};
    end
  end

  // top bit drops RST_DIV_SYNC_NUM edges after rst_tmp falls
  assign rstdiv0 = rstdiv0_sync_r[RST_DIV_SYNC_NUM-1];

  // ****************************************
  // checks
  // ****************************************

  // fabric reset must cover the whole input reset window
  a_rstdiv0_covers_rst : assert property (
    @(posedge clk_bufg) rst_tmp |-> rstdiv0
  ) else $error("rstdiv0 low while rst_tmp high");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# compile the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_infra_ctrl \
  -f sim.f \
  -o sim_infra_ctrl

./obj_dir/sim_infra_ctrl | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* sim.f */
hw/infra_pkg.sv
hw/ps_pkg.sv
hw/rst_div_sync.sv
hw/lock_monitor.sv
hw/ps_cmd_fifo.sv
hw/ps_ctrl.sv
hw/infra_ctrl_top.sv
dv/tb_infra_ctrl.sv
